// ==== bench/lsu_tb.sv ====
/*
 * load/store stage testbench
 * directed tests plus LFSR-driven traffic against a byte-level
 * reference memory, with latency and handshake checks
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb;

    localparam int DIRECTED_REQUESTS = 20;
    localparam int PREFILL_WORDS     = 16;
    localparam int RANDOM_OPS        = 200;
    localparam int NUM_REQUESTS      = DIRECTED_REQUESTS + PREFILL_WORDS + RANDOM_OPS;
    localparam int WATCHDOG_CYCLES   = NUM_REQUESTS * 4 + 200;
    localparam int REG_PAD           = `LSU_XLEN - `LSU_REG_BITS;
    localparam logic [31:0] RAND_BASE = 32'h0000_0200;

    logic                     clk;
    logic                     rst;
    logic                     valid;
    logic [`LSU_XLEN-1:0]     alu_result;
    logic [`LSU_XLEN-1:0]     store_data;
    lsu_pkg::load_type_e      load_type;
    lsu_pkg::store_type_e     store_type;
    logic [`LSU_REG_BITS-1:0] wreg;
    logic                     wd;
    logic [`LSU_XLEN-1:0]     csr_wdata;
    logic                     valid_o;
    logic                     busy_o;
    logic                     memory_inst_o;
    logic [`LSU_XLEN-1:0]     wdata_o;
    logic [`LSU_REG_BITS-1:0] wreg_o;
    logic                     wd_o;
    logic [`LSU_XLEN-1:0]     csr_wdata_o;

    // byte model of the data SRAM over address bits 11:0
    logic [7:0]  ref_mem [0:4095];
    logic [15:0] lfsr;

    lsu_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid),
        .alu_result_i  (alu_result),
        .store_data_i  (store_data),
        .load_type_i   (load_type),
        .store_type_i  (store_type),
        .wreg_i        (wreg),
        .wd_i          (wd),
        .csr_wdata_i   (csr_wdata),
        .valid_o       (valid_o),
        .busy_o        (busy_o),
        .memory_inst_o (memory_inst_o),
        .wdata_o       (wdata_o),
        .wreg_o        (wreg_o),
        .wd_o          (wd_o),
        .csr_wdata_o   (csr_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

    task automatic check_word(input logic [`LSU_XLEN-1:0] got, input logic [`LSU_XLEN-1:0] exp,
                              input string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, msg, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, msg, got, exp);
            abort_run();
        end
    endtask

    // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                             input lsu_pkg::load_type_e lt);
        logic [11:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[11:0];
        b = ref_mem[a];
        h = {ref_mem[a + 12'd1], ref_mem[a]};
        case (lt)
            lsu_pkg::LOAD_LB:  return {{24{b[7]}}, b};
            lsu_pkg::LOAD_LH:  return {{16{h[15]}}, h};
            lsu_pkg::LOAD_LBU: return {24'h0, b};
            lsu_pkg::LOAD_LHU: return {16'h0, h};
            lsu_pkg::LOAD_LW:  return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], h};
            default:           return '0;
        endcase
    endfunction

    task automatic ref_store(input logic [31:0] addr, input logic [31:0] d,
                             input lsu_pkg::store_type_e st);
        logic [11:0] a;
        a = addr[11:0];
        if (st != lsu_pkg::STORE_NONE) begin
            ref_mem[a] = d[7:0];
        end
        if (st == lsu_pkg::STORE_SH || st == lsu_pkg::STORE_SW) begin
            ref_mem[a + 12'd1] = d[15:8];
        end
        if (st == lsu_pkg::STORE_SW) begin
            ref_mem[a + 12'd2] = d[23:16];
            ref_mem[a + 12'd3] = d[31:24];
        end
    endtask

    // one request checked for latency, handshake and every output field
    task automatic do_request(input logic [31:0] addr, input logic [31:0] sdata,
                              input lsu_pkg::load_type_e lt, input lsu_pkg::store_type_e st,
                              input logic [4:0] rd, input logic rd_en, input logic [31:0] csr,
                              output logic [31:0] wdata_seen);
        logic [31:0] exp_wdata;
        logic        exp_mem;
        logic [31:0] edges;
        exp_wdata = (lt != lsu_pkg::LOAD_NONE) ? ref_load(addr, lt) : addr;
        exp_mem   = (lt != lsu_pkg::LOAD_NONE) || (st != lsu_pkg::STORE_NONE);
        @(posedge clk);
        valid      <= 1'b1;
        alu_result <= addr;
        store_data <= sdata;
        load_type  <= lt;
        store_type <= st;
        wreg       <= rd;
        wd         <= rd_en;
        csr_wdata  <= csr;
        // sampling edge
        @(posedge clk);
        valid <= 1'b0;
        edges = 32'd1;
        @(negedge clk);
        check_bit(busy_o, 1'b1, "busy_o after accept");
        while (!valid_o && edges < 32'd8) begin
            @(posedge clk);
            edges = edges + 32'd1;
            @(negedge clk);
        end
        if (!valid_o) begin
            $display("timeout: no valid_o for request at address %h", addr);
            abort_run();
        end
        check_word(edges, 32'd2, "valid_o latency in edges");
        check_bit(busy_o, 1'b1, "busy_o during the response");
        check_word(wdata_o, exp_wdata, "wdata_o");
        check_bit(memory_inst_o, exp_mem, "memory_inst_o");
        check_word({{REG_PAD{1'b0}}, wreg_o}, {{REG_PAD{1'b0}}, rd}, "wreg_o");
        check_bit(wd_o, rd_en, "wd_o");
        check_word(csr_wdata_o, csr, "csr_wdata_o");
        wdata_seen = wdata_o;
        @(posedge clk);
        @(negedge clk);
        check_bit(valid_o, 1'b0, "valid_o after the pulse");
        check_bit(busy_o, 1'b0, "busy_o after the response");
        ref_store(addr, sdata, st);
    endtask

    task automatic test_reset();
        repeat (6) begin
            @(negedge clk);
            check_bit(valid_o, 1'b0, "valid_o idle after reset");
            check_bit(busy_o, 1'b0, "busy_o idle after reset");
        end
    endtask

    task automatic test_word_round_trip();
        logic [31:0] got;
        do_request(32'h040, 32'hCAFE_F00D, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW,
                   5'd0, 1'b0, 32'h0, got);
        do_request(32'h040, 32'h0, lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE,
                   5'd5, 1'b1, 32'h0, got);
        check_word(got, 32'hCAFE_F00D, "LW after SW");
    endtask

    task automatic test_subword();
        logic [31:0] got;
        do_request(32'h100, 32'h1122_3344, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW,
                   5'd0, 1'b0, 32'h0, got);
        do_request(32'h101, 32'hAAAA_AA85, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SB,
                   5'd0, 1'b0, 32'h0, got);
        do_request(32'h102, 32'h5555_F00D, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SH,
                   5'd0, 1'b0, 32'h0, got);
        do_request(32'h100, 32'h0, lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE,
                   5'd1, 1'b1, 32'h0, got);
        check_word(got, 32'hF00D_8544, "merged sub-word stores");
        do_request(32'h101, 32'h0, lsu_pkg::LOAD_LB, lsu_pkg::STORE_NONE,
                   5'd2, 1'b1, 32'h0, got);
        do_request(32'h101, 32'h0, lsu_pkg::LOAD_LBU, lsu_pkg::STORE_NONE,
                   5'd3, 1'b1, 32'h0, got);
        do_request(32'h102, 32'h0, lsu_pkg::LOAD_LH, lsu_pkg::STORE_NONE,
                   5'd4, 1'b1, 32'h0, got);
        do_request(32'h102, 32'h0, lsu_pkg::LOAD_LHU, lsu_pkg::STORE_NONE,
                   5'd6, 1'b1, 32'h0, got);
        do_request(32'h100, 32'h0, lsu_pkg::LOAD_LB, lsu_pkg::STORE_NONE,
                   5'd7, 1'b1, 32'h0, got);
    endtask

    task automatic test_passthrough();
        logic [31:0] got;
        do_request(32'h1234_5678, 32'hFFFF_0000, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE,
                   5'd17, 1'b1, 32'h0BAD_C0DE, got);
        do_request(32'h080, 32'h0F0F_7777, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW,
                   5'd3, 1'b0, 32'h5A5A_A5A5, got);
        do_request(32'h080, 32'h0, lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE,
                   5'd31, 1'b1, 32'hFFFF_FFFF, got);
    endtask

    task automatic test_busy_strobe();
        logic [31:0] pulses;
        logic [31:0] got;
        @(posedge clk);
        valid      <= 1'b1;
        alu_result <= 32'h0C0;
        store_data <= 32'h1111_2222;
        load_type  <= lsu_pkg::LOAD_NONE;
        store_type <= lsu_pkg::STORE_SW;
        @(posedge clk);
        // second strobe lands while busy
        store_data <= 32'h9999_AAAA;
        @(posedge clk);
        valid <= 1'b0;
        pulses = 32'd0;
        repeat (6) begin
            @(negedge clk);
            if (valid_o) begin
                pulses = pulses + 32'd1;
            end
            @(posedge clk);
        end
        check_word(pulses, 32'd1, "valid_o pulses for strobe while busy");
        ref_store(32'h0C0, 32'h1111_2222, lsu_pkg::STORE_SW);
        do_request(32'h0C0, 32'h0, lsu_pkg::LOAD_LW, lsu_pkg::STORE_NONE,
                   5'd9, 1'b1, 32'h0, got);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] got;
        logic [2:0]  op;
        logic [3:0]  word;
        logic [1:0]  off;
        lsu_pkg::load_type_e  lt;
        lsu_pkg::store_type_e st;
        for (int i = 0; i < PREFILL_WORDS; i++) begin
            r = rand_bits(32);
            do_request(RAND_BASE | (i * 4), r, lsu_pkg::LOAD_NONE, lsu_pkg::STORE_SW,
                       5'd0, 1'b0, 32'h0, got);
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = rand_bits(3);
            op = r[2:0];
            r = rand_bits(4);
            word = r[3:0];
            r = rand_bits(2);
            off = r[1:0];
            lt = lsu_pkg::LOAD_NONE;
            st = lsu_pkg::STORE_NONE;
            case (op)
                3'd0: st = lsu_pkg::STORE_SB;
                3'd1: st = lsu_pkg::STORE_SH;
                3'd2: st = lsu_pkg::STORE_SW;
                3'd3: lt = lsu_pkg::LOAD_LB;
                3'd4: lt = lsu_pkg::LOAD_LH;
                3'd5: lt = lsu_pkg::LOAD_LW;
                3'd6: lt = lsu_pkg::LOAD_LBU;
                default: lt = lsu_pkg::LOAD_LHU;
            endcase
            // keep every access naturally aligned
            if (op == 3'd2 || op == 3'd5) begin
                off = 2'b00;
            end else if (op == 3'd1 || op == 3'd4 || op == 3'd7) begin
                off = {off[1], 1'b0};
            end
            r = rand_bits(32);
            do_request(RAND_BASE | {26'h0, word, off}, r, lt, st,
                       r[4:0], r[5], ~r, got);
        end
    endtask

    initial begin
        rst        = 1'b1;
        valid      = 1'b0;
        alu_result = '0;
        store_data = '0;
        load_type  = lsu_pkg::LOAD_NONE;
        store_type = lsu_pkg::STORE_NONE;
        wreg       = '0;
        wd         = 1'b0;
        csr_wdata  = '0;
        lfsr       = 16'd48635;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_word_round_trip();
        test_subword();
        test_passthrough();
        test_busy_strobe();
        test_random();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== hw/lsu_ctrl.sv ====
/*
 * load/store controller
 * accepts one request while idle, holds it until the response and
 * drives the SRAM access with lane-replicated data and a shifted mask
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_i,
    input  logic [`LSU_XLEN-1:0]              alu_result_i,
    input  logic [`LSU_XLEN-1:0]              store_data_i,
    input  lsu_pkg::load_type_e               load_type_i,
    input  lsu_pkg::store_type_e              store_type_i,
    input  logic [`LSU_REG_BITS-1:0]          wreg_i,
    input  logic                              wd_i,
    input  logic [`LSU_XLEN-1:0]              csr_wdata_i,
    output logic                              busy_o,
    output logic                              resp_valid_o,
    output logic                              mem_wen_o,
    output logic                              mem_ren_o,
    output logic [$clog2(`LSU_MEM_WORDS)-1:0] mem_word_addr_o,
    output logic [`LSU_XLEN-1:0]              mem_wdata_o,
    output lsu_pkg::byte_mask_t               mem_wmask_o,
    output lsu_pkg::load_type_e               req_load_type_o,
    output logic [1:0]                        req_byte_offset_o,
    output logic [`LSU_XLEN-1:0]              req_alu_result_o,
    output logic [`LSU_REG_BITS-1:0]          req_wreg_o,
    output logic                              req_wd_o,
    output logic [`LSU_XLEN-1:0]              req_csr_wdata_o,
    output logic                              memory_inst_o
);

    localparam int WORD_AW = $clog2(`LSU_MEM_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND
    } state_e;

    state_e               state;
    lsu_pkg::store_type_e req_store_type;
    logic                 accept;
    lsu_pkg::byte_mask_t  base_mask;
    logic [`LSU_XLEN-1:0] lane_wdata;

    // strobes while busy are dropped
    assign accept = valid_i && (state == ST_IDLE);

    // mask for lane 0 and data copied into every lane
    always_comb begin
        case (store_type_i)
            lsu_pkg::STORE_SB: begin
                base_mask  = 4'b0001;
                lane_wdata = {4{store_data_i[7:0]}};
            end
            lsu_pkg::STORE_SH: begin
                base_mask  = 4'b0011;
                lane_wdata = {2{store_data_i[15:0]}};
            end
            lsu_pkg::STORE_SW: begin
                base_mask  = 4'b1111;
                lane_wdata = store_data_i;
            end
            default: begin
                base_mask  = '0;
                lane_wdata = store_data_i;
            end
        endcase
    end

    // sequencing: idle -> access -> respond -> idle
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            mem_wen_o <= 1'b0;
            mem_ren_o <= 1'b0;
        end else begin
            mem_wen_o <= 1'b0;
            mem_ren_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state     <= ST_ACCESS;
                        mem_wen_o <= (store_type_i != lsu_pkg::STORE_NONE);
                        mem_ren_o <= (load_type_i != lsu_pkg::LOAD_NONE);
                    end
                end
                ST_ACCESS:  state <= ST_RESPOND;
                ST_RESPOND: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // request capture, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req_load_type_o   <= load_type_i;
            req_store_type    <= store_type_i;
            req_byte_offset_o <= alu_result_i[1:0];
            req_alu_result_o  <= alu_result_i;
            req_wreg_o        <= wreg_i;
            req_wd_o          <= wd_i;
            req_csr_wdata_o   <= csr_wdata_i;
            mem_word_addr_o   <= alu_result_i[2 +: WORD_AW];
            mem_wdata_o       <= lane_wdata;
            mem_wmask_o       <= base_mask << alu_result_i[1:0];
        end
    end

    assign busy_o        = (state != ST_IDLE);
    assign resp_valid_o  = (state == ST_RESPOND);
    assign memory_inst_o = resp_valid_o &&
                           ((req_load_type_o != lsu_pkg::LOAD_NONE) ||
                            (req_store_type != lsu_pkg::STORE_NONE));

endmodule

// ==== hw/lsu_data_sram.sv ====
/*
 * load/store data SRAM
 * word-wide single-port memory with per-byte write enables
 * and a registered read port
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_data_sram (
    input  logic                              clk,
    input  logic                              wen_i,
    input  logic                              ren_i,
    input  logic [$clog2(`LSU_MEM_WORDS)-1:0] word_addr_i,
    input  logic [`LSU_XLEN-1:0]              wdata_i,
    input  lsu_pkg::byte_mask_t               wmask_i,
    output logic [`LSU_XLEN-1:0]              rdata_o
);

    localparam int LANES = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

    // byte-masked write, untouched lanes keep their contents
    always_ff @(posedge clk) begin
        if (wen_i) begin
            for (int b = 0; b < LANES; b++) begin
                if (wmask_i[b]) begin
                    mem[word_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // full word read, held until the next read
    always_ff @(posedge clk) begin
        if (ren_i) begin
            rdata_o <= mem[word_addr_i];
        end
    end

endmodule

// ==== hw/lsu_load_align.sv ====
/*
 * load alignment and writeback select
 * pulls the addressed lane out of the SRAM word, extends it and
 * picks load data or the ALU result for writeback
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_align (
    input  lsu_pkg::load_type_e      load_type_i,
    input  logic [1:0]               byte_offset_i,
    input  logic [`LSU_XLEN-1:0]     mem_rdata_i,
    input  logic [`LSU_XLEN-1:0]     alu_result_i,
    input  logic [`LSU_REG_BITS-1:0] wreg_i,
    input  logic                     wd_i,
    input  logic [`LSU_XLEN-1:0]     csr_wdata_i,
    output logic [`LSU_XLEN-1:0]     wdata_o,
    output logic [`LSU_REG_BITS-1:0] wreg_o,
    output logic                     wd_o,
    output logic [`LSU_XLEN-1:0]     csr_wdata_o
);

    logic [`LSU_XLEN-1:0] lane_data;

    // addressed byte or half moved down to bit 0
    assign lane_data = mem_rdata_i >> {byte_offset_i, 3'b000};

    always_comb begin
        case (load_type_i)
            lsu_pkg::LOAD_LB: begin
                wdata_o = {{(`LSU_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            end
            lsu_pkg::LOAD_LH: begin
                wdata_o = {{(`LSU_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            end
            lsu_pkg::LOAD_LW: begin
                wdata_o = lane_data;
            end
            lsu_pkg::LOAD_LBU: begin
                wdata_o = {{(`LSU_XLEN-8){1'b0}}, lane_data[7:0]};
            end
            lsu_pkg::LOAD_LHU: begin
                wdata_o = {{(`LSU_XLEN-16){1'b0}}, lane_data[15:0]};
            end
            // stores and non-memory ops write back the alu result
            default: begin
                wdata_o = alu_result_i;
            end
        endcase
    end

    // register fields pass straight through
    assign wreg_o      = wreg_i;
    assign wd_o        = wd_i;
    assign csr_wdata_o = csr_wdata_i;

endmodule

// ==== hw/lsu_macros.svh ====
/*
 * load/store unit sizing
 * data width, register index width and data SRAM depth
 */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN 32

// register file index width
`define LSU_REG_BITS 5

// data SRAM depth in words, indexed by address bits 11:2
`define LSU_MEM_WORDS 1024

`endif

// ==== hw/lsu_pkg.sv ====
/*
 * load/store unit types
 * load and store type encodings from the decoder and the byte-lane mask
 * used for SRAM writes
 */
`include "lsu_macros.svh"

package lsu_pkg;

    // load width and sign handling, LOAD_NONE means no load
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_type_e;

    // store width
    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_type_e;

    // one enable per byte lane, bit k covers bits 8k+7:8k
    typedef logic [`LSU_XLEN/8-1:0] byte_mask_t;

endpackage

// ==== hw/lsu_top.sv ====
/*
 * load/store stage top level
 * controller, data SRAM and load alignment
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_i,
    input  logic [`LSU_XLEN-1:0]     alu_result_i,
    input  logic [`LSU_XLEN-1:0]     store_data_i,
    input  lsu_pkg::load_type_e      load_type_i,
    input  lsu_pkg::store_type_e     store_type_i,
    input  logic [`LSU_REG_BITS-1:0] wreg_i,
    input  logic                     wd_i,
    input  logic [`LSU_XLEN-1:0]     csr_wdata_i,
    output logic                     valid_o,
    output logic                     busy_o,
    output logic                     memory_inst_o,
    output logic [`LSU_XLEN-1:0]     wdata_o,
    output logic [`LSU_REG_BITS-1:0] wreg_o,
    output logic                     wd_o,
    output logic [`LSU_XLEN-1:0]     csr_wdata_o
);

    // sram request, registered in the controller
    logic                              mem_wen;
    logic                              mem_ren;
    logic [$clog2(`LSU_MEM_WORDS)-1:0] mem_word_addr;
    logic [`LSU_XLEN-1:0]              mem_wdata;
    lsu_pkg::byte_mask_t               mem_wmask;
    logic [`LSU_XLEN-1:0]              mem_rdata;

    // held request fields
    lsu_pkg::load_type_e               req_load_type;
    logic [1:0]                        req_byte_offset;
    logic [`LSU_XLEN-1:0]              req_alu_result;
    logic [`LSU_REG_BITS-1:0]          req_wreg;
    logic                              req_wd;
    logic [`LSU_XLEN-1:0]              req_csr_wdata;

    lsu_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .valid_i           (valid_i),
        .alu_result_i      (alu_result_i),
        .store_data_i      (store_data_i),
        .load_type_i       (load_type_i),
        .store_type_i      (store_type_i),
        .wreg_i            (wreg_i),
        .wd_i              (wd_i),
        .csr_wdata_i       (csr_wdata_i),
        .busy_o            (busy_o),
        .resp_valid_o      (valid_o),
        .mem_wen_o         (mem_wen),
        .mem_ren_o         (mem_ren),
        .mem_word_addr_o   (mem_word_addr),
        .mem_wdata_o       (mem_wdata),
        .mem_wmask_o       (mem_wmask),
        .req_load_type_o   (req_load_type),
        .req_byte_offset_o (req_byte_offset),
        .req_alu_result_o  (req_alu_result),
        .req_wreg_o        (req_wreg),
        .req_wd_o          (req_wd),
        .req_csr_wdata_o   (req_csr_wdata),
        .memory_inst_o     (memory_inst_o)
    );

    lsu_data_sram u_sram (
        .clk         (clk),
        .wen_i       (mem_wen),
        .ren_i       (mem_ren),
        .word_addr_i (mem_word_addr),
        .wdata_i     (mem_wdata),
        .wmask_i     (mem_wmask),
        .rdata_o     (mem_rdata)
    );

    lsu_load_align u_align (
        .load_type_i   (req_load_type),
        .byte_offset_i (req_byte_offset),
        .mem_rdata_i   (mem_rdata),
        .alu_result_i  (req_alu_result),
        .wreg_i        (req_wreg),
        .wd_i          (req_wd),
        .csr_wdata_i   (req_csr_wdata),
        .wdata_o       (wdata_o),
        .wreg_o        (wreg_o),
        .wd_o          (wd_o),
        .csr_wdata_o   (csr_wdata_o)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the load/store stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module lsu_tb -f src.f -o lsu_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "FAIL: failure reported in $LOG"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "FAIL: simulator exited with status $sim_status"
    exit 1
fi

echo "PASS: see $LOG"
exit 0

// ==== src.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_ctrl.sv
hw/lsu_data_sram.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
bench/lsu_tb.sv
